//--- rtl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes ----------------------------
    localparam logic [6:0] OpImm   = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OpReg   = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OpLoad  = 7'b0000011;
    localparam logic [6:0] OpStore = 7'b0100011;

    // ALU funct3, shared by the imm and reg groups
    localparam logic [2:0] F3Add  = 3'b000;  // ADD, SUB, ADDI
    localparam logic [2:0] F3Sll  = 3'b001;
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Sltu = 3'b011;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Srl  = 3'b101;  // SRA when funct7 bit 5 set
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;

    // Load widths
    localparam logic [2:0] F3Lb  = 3'b000;
    localparam logic [2:0] F3Lh  = 3'b001;
    localparam logic [2:0] F3Lw  = 3'b010;
    localparam logic [2:0] F3Lbu = 3'b100;
    localparam logic [2:0] F3Lhu = 3'b101;

    // Store widths
    localparam logic [2:0] F3Sb = 3'b000;
    localparam logic [2:0] F3Sh = 3'b001;
    localparam logic [2:0] F3Sw = 3'b010;

    // Instruction word views ----------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;     // Also holds shamt and funct7 for shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;    // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;    // imm[4:0]
        logic [6:0] opcode;
    } sType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
    } rvInstr_u;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluSll, AluSlt, AluSltu,
        AluXor, AluSrl, AluSra, AluOr, AluAnd
    } aluFn_e;

    typedef enum logic [2:0] {
        LdByte, LdHalf, LdWord, LdByteU, LdHalfU
    } loadMode_e;

endpackage

`default_nettype wire

//--- rtl/rvPipePkg.sv
`default_nettype none

package rvPipePkg;

    localparam int Xlen     = 32;
    localparam int RegAddrW = 5;
    localparam int ByteEnW  = 4;

    // Store lane patterns, low lanes only
    localparam logic [ByteEnW-1:0] BeByte = 4'b0001;
    localparam logic [ByteEnW-1:0] BeHalf = 4'b0011;
    localparam logic [ByteEnW-1:0] BeWord = 4'b1111;

    typedef logic [Xlen-1:0]     word_t;
    typedef logic [RegAddrW-1:0] regAddr_t;

    // Stage registers ----------------------------
    typedef struct packed {
        logic                 regWrite;
        logic                 memRead;
        logic                 memWrite;
        logic                 memToReg;   // Load data to rd
        logic                 aluSrcImm;  // Operand B from imm
        rvIsaPkg::aluFn_e     aluFn;
        rvIsaPkg::loadMode_e  loadMode;
        logic [ByteEnW-1:0]   byteEn;
        regAddr_t             rs1;
        regAddr_t             rs2;
        regAddr_t             rd;
        word_t                rs1Data;
        word_t                rs2Data;
        word_t                imm;
    } idEx_t;

    typedef struct packed {
        logic                 regWrite;
        logic                 memRead;
        logic                 memWrite;
        logic                 memToReg;
        rvIsaPkg::loadMode_e  loadMode;
        logic [ByteEnW-1:0]   byteEn;
        regAddr_t             rd;
        word_t                aluOut;     // Result or memory address
        word_t                storeData;  // Forwarded rs2
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        regAddr_t rd;
        word_t    data;
    } wbBus_t;

    // Data memory port
    typedef struct packed {
        logic               wen;
        logic [ByteEnW-1:0] byteEn;
        word_t              addr;
        word_t              wdata;
    } dmemReq_t;

endpackage

`default_nettype wire

//--- rtl/rvRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module rvRegFile (
    input  logic                clk,
    input  logic                rst_n,
    input  rvPipePkg::regAddr_t rs1Addr,
    input  rvPipePkg::regAddr_t rs2Addr,
    input  rvPipePkg::wbBus_t   wb,
    output rvPipePkg::word_t    rs1Data,
    output rvPipePkg::word_t    rs2Data
);
    import rvPipePkg::*;

    word_t regs [2**RegAddrW];
    logic  wrEn;

    assign wrEn = wb.regWrite && (wb.rd != '0);  // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**RegAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Reads see a write landing this cycle
    assign rs1Data = (rs1Addr == '0) ? '0 :
                     (wrEn && wb.rd == rs1Addr) ? wb.data : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 :
                     (wrEn && wb.rd == rs2Addr) ? wb.data : regs[rs2Addr];

endmodule

`default_nettype wire

//--- rtl/rvDecode.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecode (
    input  logic               clk,
    input  logic               rst_n,
    input  rvIsaPkg::rvInstr_u instr,
    input  rvPipePkg::wbBus_t  wb,
    output rvPipePkg::idEx_t   idEx
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    idEx_t idNext;
    word_t rs1Data;
    word_t rs2Data;

    // funct3 plus the alternate bit to ALU function
    function automatic aluFn_e aluFnFor(logic [2:0] funct3, logic alt);
        case (funct3)
            F3Add:   return alt ? AluSub : AluAdd;
            F3Sll:   return AluSll;
            F3Slt:   return AluSlt;
            F3Sltu:  return AluSltu;
            F3Xor:   return AluXor;
            F3Srl:   return alt ? AluSra : AluSrl;
            F3Or:    return AluOr;
            F3And:   return AluAnd;
            default: return AluAdd;
        endcase
    endfunction

    rvRegFile regFile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1Addr (instr.r.rs1),
        .rs2Addr (instr.r.rs2),
        .wb      (wb),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // Control decode ------------------------------
    always_comb begin
        idNext          = '0;                 // Unknown opcodes write nothing
        idNext.aluFn    = AluAdd;             // Address add for loads and stores
        idNext.loadMode = LdWord;
        idNext.rs1      = instr.r.rs1;
        idNext.rs2      = instr.r.rs2;
        idNext.rd       = instr.r.rd;
        idNext.rs1Data  = rs1Data;
        idNext.rs2Data  = rs2Data;
        idNext.imm      = {{(Xlen-12){instr.i.imm[11]}}, instr.i.imm};

        case (instr.r.opcode)
            OpImm: begin
                idNext.regWrite  = 1'b1;
                idNext.aluSrcImm = 1'b1;
                // Bit 30 is immediate except for SRAI
                idNext.aluFn = aluFnFor(instr.i.funct3,
                                        instr.r.funct7[5] && instr.i.funct3 == F3Srl);
            end
            OpReg: begin
                idNext.regWrite = 1'b1;
                idNext.aluFn    = aluFnFor(instr.r.funct3, instr.r.funct7[5]);
            end
            OpLoad: begin
                idNext.regWrite  = 1'b1;
                idNext.memRead   = 1'b1;
                idNext.memToReg  = 1'b1;
                idNext.aluSrcImm = 1'b1;
                case (instr.i.funct3)
                    F3Lb:    idNext.loadMode = LdByte;
                    F3Lh:    idNext.loadMode = LdHalf;
                    F3Lw:    idNext.loadMode = LdWord;
                    F3Lbu:   idNext.loadMode = LdByteU;
                    F3Lhu:   idNext.loadMode = LdHalfU;
                    default: idNext.loadMode = LdWord;
                endcase
            end
            OpStore: begin
                idNext.memWrite  = 1'b1;
                idNext.aluSrcImm = 1'b1;
                idNext.imm = {{(Xlen-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
                case (instr.s.funct3)
                    F3Sb:    idNext.byteEn = BeByte;
                    F3Sh:    idNext.byteEn = BeHalf;
                    F3Sw:    idNext.byteEn = BeWord;
                    default: idNext.memWrite = 1'b0;  // No lanes, no write
                endcase
            end
            default: ;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else begin
            idEx <= idNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rvExecute.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecute (
    input  logic              clk,
    input  logic              rst_n,
    input  rvPipePkg::idEx_t  idEx,
    input  rvPipePkg::wbBus_t wb,
    output rvPipePkg::exMem_t exMem
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    word_t                    opA;
    word_t                    opB;
    word_t                    rs2Fwd;     // Also the store data
    word_t                    aluOut;
    logic [$clog2(Xlen)-1:0]  shAmt;
    exMem_t                   exNext;

    // Newest producer wins, x0 never forwarded
    function automatic word_t fwdOperand(regAddr_t rs, word_t regVal,
                                         exMem_t exMemQ, wbBus_t wbQ);
        if (exMemQ.regWrite && exMemQ.rd != '0 && exMemQ.rd == rs) begin
            return exMemQ.aluOut;
        end
        if (wbQ.regWrite && wbQ.rd != '0 && wbQ.rd == rs) begin
            return wbQ.data;
        end
        return regVal;
    endfunction

    // Operand select ------------------------------
    assign opA    = fwdOperand(idEx.rs1, idEx.rs1Data, exMem, wb);
    assign rs2Fwd = fwdOperand(idEx.rs2, idEx.rs2Data, exMem, wb);
    assign opB    = idEx.aluSrcImm ? idEx.imm : rs2Fwd;
    assign shAmt  = opB[$clog2(Xlen)-1:0];  // Low five bits only

    // ALU -----------------------------------------
    always_comb begin
        case (idEx.aluFn)
            AluAdd:  aluOut = opA + opB;
            AluSub:  aluOut = opA - opB;
            AluSll:  aluOut = opA << shAmt;
            AluSlt:  aluOut = word_t'($signed(opA) < $signed(opB));
            AluSltu: aluOut = word_t'(opA < opB);  // Unsigned compare
            AluXor:  aluOut = opA ^ opB;
            AluSrl:  aluOut = opA >> shAmt;
            AluSra:  aluOut = word_t'($signed(opA) >>> shAmt);
            AluOr:   aluOut = opA | opB;
            AluAnd:  aluOut = opA & opB;
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        exNext.regWrite  = idEx.regWrite;
        exNext.memRead   = idEx.memRead;
        exNext.memWrite  = idEx.memWrite;
        exNext.memToReg  = idEx.memToReg;
        exNext.loadMode  = idEx.loadMode;
        exNext.byteEn    = idEx.byteEn;
        exNext.rd        = idEx.rd;
        exNext.aluOut    = aluOut;
        exNext.storeData = rs2Fwd;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else begin
            exMem <= exNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rvMemAccess.sv
`timescale 1ns/1ps
`default_nettype none

module rvMemAccess (
    input  logic                clk,
    input  logic                rst_n,
    input  rvPipePkg::exMem_t   exMem,
    input  rvPipePkg::word_t    dmemRData,
    output rvPipePkg::dmemReq_t dmemReq,
    output rvPipePkg::wbBus_t   wb
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        regAddr_t rd;
        word_t    aluOut;
        word_t    loadData;
    } memWb_t;

    memWb_t memWb;
    word_t  loadData;

    assign dmemReq = '{wen: exMem.memWrite, byteEn: exMem.byteEn,
                       addr: exMem.aluOut, wdata: exMem.storeData};

    // Load extension from the low lanes
    always_comb begin
        case (exMem.loadMode)
            LdByte:  loadData = {{(Xlen-8){dmemRData[7]}}, dmemRData[7:0]};
            LdHalf:  loadData = {{(Xlen-16){dmemRData[15]}}, dmemRData[15:0]};
            LdByteU: loadData = {{(Xlen-8){1'b0}}, dmemRData[7:0]};
            LdHalfU: loadData = {{(Xlen-16){1'b0}}, dmemRData[15:0]};
            default: loadData = dmemRData;  // LW
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.rd       <= exMem.rd;
            memWb.aluOut   <= exMem.aluOut;
            if (exMem.memRead) memWb.loadData <= loadData;  // Hold otherwise
        end
    end

    assign wb = '{regWrite: memWb.regWrite, rd: memWb.rd,
                  data: memWb.memToReg ? memWb.loadData : memWb.aluOut};

endmodule

`default_nettype wire

//--- rtl/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore (
    input  logic                clk,
    input  logic                rst_n,
    output rvPipePkg::word_t    imemAddr,
    input  rvIsaPkg::rvInstr_u  imemInsn,   // Same-cycle ROM answer
    output rvPipePkg::dmemReq_t dmemReq,
    input  rvPipePkg::word_t    dmemRData   // Same-cycle read data
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    word_t    pc;
    rvInstr_u ifId;
    idEx_t    idEx;
    exMem_t   exMem;
    wbBus_t   wb;

    // Fetch ---------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc + word_t'(4);  // No branches, straight-line fetch
        end
    end

    assign imemAddr = pc;

    // IF/ID, cleared to an opcode that writes nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifId <= '0;
        end else begin
            ifId <= imemInsn;
        end
    end

    // Stages --------------------------------------
    rvDecode decode (
        .clk   (clk),
        .rst_n (rst_n),
        .instr (ifId),
        .wb    (wb),
        .idEx  (idEx)
    );

    rvExecute execute (
        .clk   (clk),
        .rst_n (rst_n),
        .idEx  (idEx),
        .wb    (wb),     // MEM/WB forwarding
        .exMem (exMem)
    );

    rvMemAccess memAccess (
        .clk       (clk),
        .rst_n     (rst_n),
        .exMem     (exMem),
        .dmemRData (dmemRData),
        .dmemReq   (dmemReq),
        .wb        (wb)
    );

endmodule

`default_nettype wire

//--- tb/rvCoreAssertions.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreAssertions (
    input logic                clk,
    input logic                rst_n,
    input rvPipePkg::dmemReq_t dmemReq
);
    import rvPipePkg::*;

    // Cleared stage registers, so no write under reset
    noStoreInReset: assert property (@(posedge clk) !rst_n |-> !dmemReq.wen)
        else $error("data memory write enable high while reset is held");

    legalLanes: assert property (@(posedge clk) disable iff (!rst_n)
        dmemReq.wen |-> (dmemReq.byteEn == BeByte || dmemReq.byteEn == BeHalf ||
                         dmemReq.byteEn == BeWord))
        else $error("store byte enables %b are not a legal pattern", dmemReq.byteEn);

    knownReq: assert property (@(posedge clk) disable iff (!rst_n)
        dmemReq.wen |-> !$isunknown({dmemReq.addr, dmemReq.wdata}))   // No X on a write
        else $error("store address or data has unknown bits");

endmodule

bind rvCore rvCoreAssertions reqChecks (.clk(clk), .rst_n(rst_n), .dmemReq(dmemReq));

`default_nettype wire

//--- tb/rvRefModel.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH
`default_nettype none

// Expected effect of one instruction
typedef struct packed {
    logic                regWr;
    rvPipePkg::regAddr_t rd;
    rvPipePkg::word_t    data;
    logic                store;
    rvPipePkg::dmemReq_t req;    // Expected store request
} refStep_t;

// Encoders ------------------------------
function automatic rvIsaPkg::rvInstr_u iTypeWord(logic [6:0] op, logic [2:0] f3,
        rvPipePkg::regAddr_t rd, rvPipePkg::regAddr_t rs1, logic [11:0] imm);
    rvIsaPkg::rvInstr_u w;
    w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
    return w;
endfunction

function automatic rvIsaPkg::rvInstr_u rTypeWord(logic [6:0] f7, logic [2:0] f3,
        rvPipePkg::regAddr_t rd, rvPipePkg::regAddr_t rs1, rvPipePkg::regAddr_t rs2);
    rvIsaPkg::rvInstr_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: rvIsaPkg::OpReg};
    return w;
endfunction

function automatic rvIsaPkg::rvInstr_u sTypeWord(logic [2:0] f3,
        rvPipePkg::regAddr_t rs2, rvPipePkg::regAddr_t rs1, logic [11:0] imm);
    rvIsaPkg::rvInstr_u w;
    w.s = '{immHi: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3, immLo: imm[4:0],
            opcode: rvIsaPkg::OpStore};
    return w;
endfunction

function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;  // Classic LCG constants
endfunction

// RV32I semantics -----------------------
function automatic rvPipePkg::word_t aluResult(logic [2:0] f3, logic alt,
        rvPipePkg::word_t x, rvPipePkg::word_t y);
    logic [4:0] sh;
    sh = y[4:0];                                   // Shift amount is 5 bits
    case (f3)
        3'b000:  return alt ? x - y : x + y;
        3'b001:  return x << sh;
        3'b010:  return {31'b0, $signed(x) < $signed(y)};
        3'b011:  return {31'b0, x < y};            // Unsigned
        3'b100:  return x ^ y;
        3'b101: begin
            if (alt) return $signed(x) >>> sh;     // Sign bit shifted in
            return x >> sh;
        end
        3'b110:  return x | y;
        default: return x & y;
    endcase
endfunction

function automatic rvPipePkg::word_t loadExtend(logic [2:0] f3, rvPipePkg::word_t m);
    case (f3)
        3'b000:  return {{24{m[7]}}, m[7:0]};
        3'b001:  return {{16{m[15]}}, m[15:0]};
        3'b100:  return {24'b0, m[7:0]};
        3'b101:  return {16'b0, m[15:0]};
        default: return m;                         // LW
    endcase
endfunction

function automatic rvPipePkg::word_t memAddrOf(rvIsaPkg::rvInstr_u ins, rvPipePkg::word_t a);
    if (ins.r.opcode == rvIsaPkg::OpStore) begin
        return a + {{20{ins.s.immHi[6]}}, ins.s.immHi, ins.s.immLo};
    end
    return a + {{20{ins.i.imm[11]}}, ins.i.imm};
endfunction

// One instruction on operand values a, b and the addressed memory word m
function automatic refStep_t execInsn(rvIsaPkg::rvInstr_u ins, rvPipePkg::word_t a,
        rvPipePkg::word_t b, rvPipePkg::word_t m);
    refStep_t s;
    rvPipePkg::word_t iImm;
    s = '0;
    iImm = {{20{ins.i.imm[11]}}, ins.i.imm};
    s.rd = ins.i.rd;
    case (ins.r.opcode)
        rvIsaPkg::OpImm: begin
            s.regWr = 1'b1;
            s.data = aluResult(ins.i.funct3, ins.i.funct3 == 3'b101 && ins.r.funct7[5], a, iImm);
        end
        rvIsaPkg::OpReg: begin
            s.regWr = 1'b1;
            s.data = aluResult(ins.r.funct3, ins.r.funct7[5], a, b);
        end
        rvIsaPkg::OpLoad: begin
            s.regWr = 1'b1;
            s.data = loadExtend(ins.i.funct3, m);
        end
        rvIsaPkg::OpStore: begin
            s.store = 1'b1;
            s.req.wen = 1'b1;
            s.req.byteEn = (ins.s.funct3 == 3'b000) ? 4'b0001 :
                           (ins.s.funct3 == 3'b001) ? 4'b0011 : 4'b1111;
            s.req.addr = memAddrOf(ins, a);
            s.req.wdata = b;
        end
        default: ;                                 // Writes nothing
    endcase
    return s;
endfunction

`default_nettype wire
`endif

//--- tb/rvCoreTb.sv
`timescale 1ns/1ps
`include "rvRefModel.svh"
`default_nettype none

module rvCoreTb;
    import rvIsaPkg::*;
    import rvPipePkg::*;

    localparam int RomWords      = 512;
    localparam int MemWords      = 512;   // Word index from addr[10:2]
    localparam int TimeoutCycles = 2000;
    localparam int DrainCycles   = 20;    // Watch for stray stores after the last one

    logic     clk;
    logic     rst_n;
    word_t    imemAddr;
    rvInstr_u imemInsn;
    dmemReq_t dmemReq;
    word_t    dmemRData;

    rvInstr_u    prog [RomWords];
    word_t       dmem [MemWords];
    word_t       modelReg [32];
    word_t       modelMem [MemWords];
    dmemReq_t    expQ [$];           // Expected stores in program order
    word_t       expPc;              // Fetch address due this cycle
    int          progLen;
    int          storeSlot;
    logic [31:0] lcgState;
    int          checks;
    int          storesSeen;
    int          mismatches;
    int          otherErrors;
    int          cycles;

    rvCore DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .imemAddr  (imemAddr),
        .imemInsn  (imemInsn),
        .dmemReq   (dmemReq),
        .dmemRData (dmemRData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory models ------------------------
    always_comb begin
        if ((imemAddr >> 2) < word_t'(progLen)) imemInsn = prog[imemAddr[10:2]];
        else imemInsn = iTypeWord(OpImm, F3Add, 5'd0, 5'd0, 12'd0);  // NOP past the end
    end

    assign dmemRData = dmem[dmemReq.addr[10:2]];

    always @(posedge clk) begin
        if (rst_n && dmemReq.wen) begin
            dmem[dmemReq.addr[10:2]] <= (dmem[dmemReq.addr[10:2]] & ~laneMask(dmemReq.byteEn))
                                      | (dmemReq.wdata & laneMask(dmemReq.byteEn));
        end
    end

    // Odd words get bits 7 and 15 set
    function automatic word_t fillWord(int idx);
        return (word_t'(idx) * 32'h9E37_79B9 + 32'h1234_5678) | (idx[0] ? 32'h8080 : 32'h0);
    endfunction

    function automatic word_t laneMask(logic [ByteEnW-1:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function logic [11:0] randImm();
        lcgState = lcgNext(lcgState);
        return lcgState[27:16];
    endfunction

    // Program ------------------------------
    task automatic appendInsn(rvInstr_u w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic storeToSlot(regAddr_t r, logic [2:0] f3);
        appendInsn(sTypeWord(f3, r, 5'd0, 12'(storeSlot)));   // Fresh word off base x0
        storeSlot += 4;
    endtask

    task automatic buildProgram();
        logic [11:0] imm;
        logic [2:0]  f3;
        for (int round = 0; round < 2; round++) begin         // I-type with random imm
            for (int f = 0; f < 9; f++) begin
                appendInsn(iTypeWord(OpImm, F3Add, 5'd5, 5'd0, randImm()));
                imm = randImm();
                if (f == 1 || f == 5) imm[11:5] = 7'd0;        // SLLI, SRLI
                if (f == 8) imm[11:5] = 7'b0100000;            // SRAI
                appendInsn(iTypeWord(OpImm, (f == 8) ? F3Srl : 3'(f), 5'd6, 5'd5, imm));
                storeToSlot(5'd6, F3Sw);
            end
        end
        appendInsn(iTypeWord(OpImm, F3Add, 5'd5, 5'd0, 12'hFFB));  // x5 = -5
        appendInsn(iTypeWord(OpImm, F3Slt, 5'd6, 5'd5, 12'd3));
        storeToSlot(5'd6, F3Sw);
        appendInsn(iTypeWord(OpImm, F3Sltu, 5'd6, 5'd5, 12'd3));
        storeToSlot(5'd6, F3Sw);
        appendInsn(iTypeWord(OpImm, F3Srl, 5'd6, 5'd5, 12'h402));  // SRAI by 2
        storeToSlot(5'd6, F3Sw);
        appendInsn(iTypeWord(OpImm, F3Srl, 5'd6, 5'd5, 12'h002));  // SRLI by 2
        storeToSlot(5'd6, F3Sw);
        // R-type chain with x(9+f) from the one and two before
        for (int round = 0; round < 2; round++) begin
            appendInsn(iTypeWord(OpImm, F3Add, 5'd7, 5'd0, randImm()));
            appendInsn(iTypeWord(OpImm, F3Add, 5'd8, 5'd0, randImm()));
            for (int f = 0; f < 10; f++) begin
                f3 = 3'((f < 2) ? 0 : (f <= 6) ? f - 1 : f - 2);
                appendInsn(rTypeWord((f == 1 || f == 7) ? 7'b0100000 : 7'd0, f3, 5'(9 + f),
                                     5'(round == 0 ? 8 + f : 7 + f),
                                     5'(round == 0 ? 7 + f : 8 + f)));
            end
            for (int f = 0; f < 10; f++) storeToSlot(5'(9 + f), F3Sw);
        end
        appendInsn(iTypeWord(OpImm, F3Add, 5'd20, 5'd0, randImm()));  // Store widths
        storeToSlot(5'd20, F3Sb);
        storeToSlot(5'd20, F3Sh);
        storeToSlot(5'd20, F3Sw);
        for (int k = 0; k < 5; k++) begin                      // LB LH LW LBU LHU
            for (int j = 0; j < 2; j++) begin
                appendInsn(iTypeWord(OpLoad, 3'(k < 3 ? k : k + 1), 5'd21, 5'd0,
                                     12'(8 * k + 4 * j)));
                appendInsn(iTypeWord(OpImm, F3Add, 5'd3, 5'd0, randImm()));  // Load-use gap
                storeToSlot(5'd21, F3Sw);
            end
        end
        appendInsn(iTypeWord(OpImm, F3Add, 5'd0, 5'd5, randImm()));  // Writes to x0
        storeToSlot(5'd0, F3Sw);
        appendInsn(rTypeWord(7'd0, F3Add, 5'd0, 5'd5, 5'd6));
        storeToSlot(5'd0, F3Sw);
    endtask

    task automatic runModel();
        refStep_t st;
        word_t    addr;
        for (int i = 0; i < MemWords; i++) modelMem[i[8:0]] = fillWord(i);
        for (int i = 0; i < 32; i++) modelReg[i[4:0]] = '0;
        for (int p = 0; p < progLen; p++) begin
            addr = memAddrOf(prog[p[8:0]], modelReg[prog[p[8:0]].r.rs1]);
            st = execInsn(prog[p[8:0]], modelReg[prog[p[8:0]].r.rs1],
                          modelReg[prog[p[8:0]].r.rs2], modelMem[addr[10:2]]);
            if (st.regWr && st.rd != '0) modelReg[st.rd] = st.data;
            if (st.store) begin
                modelMem[st.req.addr[10:2]] = (modelMem[st.req.addr[10:2]] & ~laneMask(st.req.byteEn))
                                            | (st.req.wdata & laneMask(st.req.byteEn));
                expQ.push_back(st.req);
            end
        end
    endtask

    // Checks -------------------------------
    task automatic checkStore(dmemReq_t got, dmemReq_t want);
        checks++;
        if (got.addr !== want.addr) begin
            mismatches++;
            $display("MISMATCH at %0t: dmemReq.addr got %h expected %h", $time, got.addr, want.addr);
        end
        if (got.byteEn !== want.byteEn) begin
            mismatches++;
            $display("MISMATCH at %0t: dmemReq.byteEn got %b expected %b",
                     $time, got.byteEn, want.byteEn);
        end
        if ((got.wdata & laneMask(want.byteEn)) !== (want.wdata & laneMask(want.byteEn))) begin
            mismatches++;
            $display("MISMATCH at %0t: dmemReq.wdata got %h expected %h (lanes %b)",
                     $time, got.wdata, want.wdata, want.byteEn);
        end
    endtask

    task automatic checkIdle(dmemReq_t got);
        checks++;
        if (got.wen !== 1'b0) begin
            mismatches++;
            $display("MISMATCH at %0t: dmemReq.wen got %b expected 0", $time, got.wen);
        end
    endtask

    task automatic checkFetch(word_t got, word_t want);
        checks++;
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH at %0t: imemAddr got %h expected %h", $time, got, want);
        end
    endtask

    always @(negedge clk) begin   // Mid-cycle where the request is settled
        if (!rst_n) begin
            checkIdle(dmemReq);
            expPc = '0;
        end else begin
            checkFetch(imemAddr, expPc);
            expPc = expPc + word_t'(4);   // Straight-line fetch
            if (dmemReq.wen) begin
                storesSeen++;
                if (expQ.size() == 0) begin
                    otherErrors++;
                    $display("ERROR at %0t: store to %h that the program never issues",
                             $time, dmemReq.addr);
                end else begin
                    checkStore(dmemReq, expQ.pop_front());
                end
            end
        end
    end

    // Main sequence ------------------------
    initial begin
        rst_n       = 1'b0;
        lcgState    = 32'd49;
        progLen     = 0;
        storeSlot   = 'h200;      // Store area above the load words
        checks      = 0;
        storesSeen  = 0;
        mismatches  = 0;
        otherErrors = 0;
        for (int i = 0; i < MemWords; i++) dmem[i[8:0]] <= fillWord(i);
        buildProgram();
        runModel();
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        cycles = 0;
        while (expQ.size() != 0 && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (expQ.size() != 0) begin
            otherErrors++;
            $display("ERROR: timeout after %0d cycles, %0d expected stores never appeared",
                     cycles, expQ.size());
        end else begin
            cycles = 0;
            while (cycles < DrainCycles) begin
                @(posedge clk);
                cycles++;
            end
        end
        $display("checks %0d, stores %0d, mismatches %0d, other errors %0d",
                 checks, storesSeen, mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tb
rtl/rvIsaPkg.sv
rtl/rvPipePkg.sv
rtl/rvRegFile.sv
rtl/rvDecode.sv
rtl/rvExecute.sv
rtl/rvMemAccess.sv
rtl/rvCore.sv
tb/rvCoreAssertions.sv
tb/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in sim.log
rm -f sim.log &&
verilator --binary --timing --assert -f flist.f --top-module rvCoreTb -Mdir obj_dir -o rvCoreSim &&
./obj_dir/rvCoreSim | tee sim.log &&
grep -qx "sim passed" sim.log && echo "PASS" ||
{ echo "FAIL: see sim.log"; exit 1; }
